/* hw/rs_tag_pkg.sv */
/* rs tag package
 * rename tag space and station map of the tomasulo issue stage.
 * a tag names the producer an operand waits on, tag 0 marks a
 * value that is already present.
 */
`default_nettype none

package rs_tag_pkg;

	localparam int tag_w    = 4; // rename tag width
	localparam int ls_idx_w = 3; // load slot index width

	typedef logic [tag_w-1:0]    tag_t;
	typedef logic [ls_idx_w-1:0] ls_idx_t;

	// station counts on the arithmetic side
	localparam int num_add = 3;
	localparam int num_mul = 2;

	localparam tag_t tag_ready = 4'd0; // operand holds its value

	// station map
	// tags 1..6 load slots
	// tags 7..9 add stations 1..3
	// tags 10..11 multiply stations 1..2
	localparam tag_t tag_load_base = 4'd1;  // load slot 0
	localparam tag_t tag_add_base  = 4'd7;  // add station 1
	localparam tag_t tag_mul_base  = 4'd10; // multiply station 1

endpackage

`default_nettype wire

/* hw/rs_data_pkg.sv */
/* rs data package
 * operand and operation types carried by the reservation stations
 */
`default_nettype none

package rs_data_pkg;

	localparam int data_w = 32; // operand width
	localparam int op_w   = 3;  // operation code width

	typedef logic [data_w-1:0] data_t; // register or cdb value
	typedef logic [op_w-1:0]   op_t;   // passed to the unit as issued

endpackage

`default_nettype wire

/* hw/operand_capture.sv */
/* operand capture
 * compares one waiting rename tag with the common data bus.
 * the tag is decoded into a load slot, an add station or a multiply
 * station and matched against that producer's valid and index.
 * purely combinational, the broadcast value is returned in the
 * same cycle.
 */
`timescale 1ns/1ps
`default_nettype none

module operand_capture
	import rs_tag_pkg::*;
	import rs_data_pkg::*;
(
	input  tag_t    watch_tag,
	input  logic    add_valid [num_add],
	input  data_t   add_result [num_add],
	input  logic    mul_valid [num_mul],
	input  data_t   mul_result [num_mul],
	input  logic    ls_valid,
	input  data_t   ls_value,
	input  ls_idx_t ls_idx,
	output logic    hit,
	output data_t   value
);

	logic is_load;
	logic is_add;
	logic is_mul;
	tag_t load_tag;
	tag_t add_off;
	tag_t mul_off;

	// tag of the load slot broadcasting this cycle
	assign load_tag = tag_t'(ls_idx) + tag_load_base;

	// producer class of the watched tag, tag 0 falls in none of them
	assign is_load = (watch_tag >= tag_load_base) && (watch_tag < tag_add_base);
	assign is_add  = (watch_tag >= tag_add_base) &&
	                 (watch_tag < tag_add_base + tag_t'(num_add));
	assign is_mul  = (watch_tag >= tag_mul_base) &&
	                 (watch_tag < tag_mul_base + tag_t'(num_mul));

	assign add_off = watch_tag - tag_add_base; // station index inside the add group
	assign mul_off = watch_tag - tag_mul_base;

	always_comb begin
		hit   = 1'b0;
		value = '0;
		if (is_load && ls_valid && (watch_tag == load_tag)) begin
			hit   = 1'b1;
			value = ls_value;
		end
		for (int i = 0; i < num_add; i++) begin
			if (is_add && (add_off == tag_t'(i)) && add_valid[i]) begin
				hit   = 1'b1;
				value = add_result[i];
			end
		end
		for (int i = 0; i < num_mul; i++) begin
			if (is_mul && (mul_off == tag_t'(i)) && mul_valid[i]) begin
				hit   = 1'b1;
				value = mul_result[i];
			end
		end
	end

endmodule

`default_nettype wire

/* hw/rs_station.sv */
/* reservation station entry
 * takes an operation when the issue index names own_tag and the
 * entry is free. missing operands are picked up from the common
 * data bus, also in the issue cycle itself. once both operands are
 * present a one cycle start goes to the unit, and the entry frees
 * when its own result is broadcast.
 */
`timescale 1ns/1ps
`default_nettype none

module rs_station
	import rs_tag_pkg::*;
	import rs_data_pkg::*;
#(
	parameter tag_t own_tag = tag_add_base
) (
	input  logic    clk,
	input  logic    reset,
	input  tag_t    sel,
	input  op_t     operation,
	input  data_t   vj_in,
	input  data_t   vk_in,
	input  tag_t    qj_in,
	input  tag_t    qk_in,
	input  logic    add_valid [num_add],
	input  data_t   add_result [num_add],
	input  logic    mul_valid [num_mul],
	input  data_t   mul_result [num_mul],
	input  logic    ls_valid,
	input  data_t   ls_value,
	input  ls_idx_t ls_idx,
	output data_t   vj,
	output data_t   vk,
	output op_t     op,
	output logic    start,
	output logic    busy
);

	logic  issue;
	logic  dispatched; // start already given for this operation
	logic  own_bcast;  // own result on the cdb
	tag_t  qj;         // stored producer tags
	tag_t  qk;
	tag_t  watch_j;
	tag_t  watch_k;
	logic  hit_j;
	logic  hit_k;
	data_t cdb_j;
	data_t cdb_k;

	assign issue = (sel == own_tag) && !busy;

	// at issue the incoming tags are watched so a same cycle broadcast is caught
	assign watch_j = issue ? qj_in : qj;
	assign watch_k = issue ? qk_in : qk;

	operand_capture cap_j (
		.watch_tag  (watch_j),
		.add_valid  (add_valid),
		.add_result (add_result),
		.mul_valid  (mul_valid),
		.mul_result (mul_result),
		.ls_valid   (ls_valid),
		.ls_value   (ls_value),
		.ls_idx     (ls_idx),
		.hit        (hit_j),
		.value      (cdb_j)
	);

	operand_capture cap_k (
		.watch_tag  (watch_k),
		.add_valid  (add_valid),
		.add_result (add_result),
		.mul_valid  (mul_valid),
		.mul_result (mul_result),
		.ls_valid   (ls_valid),
		.ls_value   (ls_value),
		.ls_idx     (ls_idx),
		.hit        (hit_k),
		.value      (cdb_k)
	);

	// pick the valid line of this station's own unit
	always_comb begin
		own_bcast = 1'b0;
		for (int i = 0; i < num_add; i++) begin
			if (own_tag == tag_add_base + tag_t'(i))
				own_bcast = add_valid[i];
		end
		for (int i = 0; i < num_mul; i++) begin
			if (own_tag == tag_mul_base + tag_t'(i))
				own_bcast = mul_valid[i];
		end
	end

	assign start = busy && !dispatched && (qj == tag_ready) && (qk == tag_ready);

	always_ff @(posedge clk) begin
		if (reset) begin
			busy       <= 1'b0;
			dispatched <= 1'b0;
			qj         <= tag_ready;
			qk         <= tag_ready;
		end else if (issue) begin
			busy       <= 1'b1;
			dispatched <= 1'b0;
			qj         <= (qj_in == tag_ready || hit_j) ? tag_ready : qj_in;
			qk         <= (qk_in == tag_ready || hit_k) ? tag_ready : qk_in;
		end else begin
			if (busy && own_bcast)
				busy <= 1'b0; // free from the next cycle on
			if (start)
				dispatched <= 1'b1;
			if (hit_j)
				qj <= tag_ready;
			if (hit_k)
				qk <= tag_ready;
		end
	end

	// operand and opcode storage
	always_ff @(posedge clk) begin
		if (issue) begin
			op <= operation;
			vj <= hit_j ? cdb_j : vj_in; // register value unless the bus delivers now
			vk <= hit_k ? cdb_k : vk_in;
		end else begin
			if (hit_j)
				vj <= cdb_j;
			if (hit_k)
				vk <= cdb_k;
		end
	end

endmodule

`default_nettype wire

/* hw/rs_top.sv */
/* reservation station top
 * arithmetic side of the issue stage with three add and two
 * multiply stations. every station sees the same issue lines and
 * common data bus, and its rename tag comes from the station map.
 */
`timescale 1ns/1ps
`default_nettype none

module rs_top
	import rs_tag_pkg::*;
	import rs_data_pkg::*;
(
	input  logic    clk,
	input  logic    reset,

	// issue
	input  tag_t    sel,
	input  op_t     operation,
	input  data_t   vj,
	input  data_t   vk,
	input  tag_t    qj,
	input  tag_t    qk,

	// common data bus
	input  logic    add_valid [num_add],
	input  data_t   add_result [num_add],
	input  logic    mul_valid [num_mul],
	input  data_t   mul_result [num_mul],
	input  logic    ls_valid,
	input  data_t   ls_value,
	input  ls_idx_t ls_idx,

	// add units
	output data_t   add_vj [num_add],
	output data_t   add_vk [num_add],
	output op_t     add_op [num_add],
	output logic    add_start [num_add],
	output logic    add_busy [num_add],

	// multiply units
	output data_t   mul_vj [num_mul],
	output data_t   mul_vk [num_mul],
	output op_t     mul_op [num_mul],
	output logic    mul_start [num_mul],
	output logic    mul_busy [num_mul]
);

	for (genvar i = 0; i < num_add; i++) begin : g_add
		rs_station #(
			.own_tag (tag_add_base + tag_t'(i)) // tags 7..9
		) add_rs (
			.clk        (clk),
			.reset      (reset),
			.sel        (sel),
			.operation  (operation),
			.vj_in      (vj),
			.vk_in      (vk),
			.qj_in      (qj),
			.qk_in      (qk),
			.add_valid  (add_valid),
			.add_result (add_result),
			.mul_valid  (mul_valid),
			.mul_result (mul_result),
			.ls_valid   (ls_valid),
			.ls_value   (ls_value),
			.ls_idx     (ls_idx),
			.vj         (add_vj[i]),
			.vk         (add_vk[i]),
			.op         (add_op[i]),
			.start      (add_start[i]),
			.busy       (add_busy[i])
		);
	end

	for (genvar i = 0; i < num_mul; i++) begin : g_mul
		rs_station #(
			.own_tag (tag_mul_base + tag_t'(i)) // tags 10..11
		) mul_rs (
			.clk        (clk),
			.reset      (reset),
			.sel        (sel),
			.operation  (operation),
			.vj_in      (vj),
			.vk_in      (vk),
			.qj_in      (qj),
			.qk_in      (qk),
			.add_valid  (add_valid),
			.add_result (add_result),
			.mul_valid  (mul_valid),
			.mul_result (mul_result),
			.ls_valid   (ls_valid),
			.ls_value   (ls_value),
			.ls_idx     (ls_idx),
			.vj         (mul_vj[i]),
			.vk         (mul_vk[i]),
			.op         (mul_op[i]),
			.start      (mul_start[i]),
			.busy       (mul_busy[i])
		);
	end

endmodule

`default_nettype wire

/* verif/rs_top_tb.sv */
/* reservation station testbench
 * directed tests on the arithmetic issue stage. covers reset state,
 * issue with ready operands, wake-up on a later broadcast, capture in
 * the issue cycle and an issue to a station that is still busy.
 */
`timescale 1ns/1ps
`default_nettype none

module rs_top_tb
	import rs_tag_pkg::*;
	import rs_data_pkg::*;
;

	localparam int test_cycles = 150;             // summed length of all tests
	localparam int watchdog_cycles = 2 * test_cycles;

	logic    clk;
	logic    reset;
	tag_t    sel;
	op_t     operation;
	data_t   vj;
	data_t   vk;
	tag_t    qj;
	tag_t    qk;
	logic    add_valid [num_add];
	data_t   add_result [num_add];
	logic    mul_valid [num_mul];
	data_t   mul_result [num_mul];
	logic    ls_valid;
	data_t   ls_value;
	ls_idx_t ls_idx;
	data_t   add_vj [num_add];
	data_t   add_vk [num_add];
	op_t     add_op [num_add];
	logic    add_start [num_add];
	logic    add_busy [num_add];
	data_t   mul_vj [num_mul];
	data_t   mul_vk [num_mul];
	op_t     mul_op [num_mul];
	logic    mul_start [num_mul];
	logic    mul_busy [num_mul];

	rs_top rs_top_i (
		.clk        (clk),
		.reset      (reset),
		.sel        (sel),
		.operation  (operation),
		.vj         (vj),
		.vk         (vk),
		.qj         (qj),
		.qk         (qk),
		.add_valid  (add_valid),
		.add_result (add_result),
		.mul_valid  (mul_valid),
		.mul_result (mul_result),
		.ls_valid   (ls_valid),
		.ls_value   (ls_value),
		.ls_idx     (ls_idx),
		.add_vj     (add_vj),
		.add_vk     (add_vk),
		.add_op     (add_op),
		.add_start  (add_start),
		.add_busy   (add_busy),
		.mul_vj     (mul_vj),
		.mul_vk     (mul_vk),
		.mul_op     (mul_op),
		.mul_start  (mul_start),
		.mul_busy   (mul_busy)
	);

	always #50 clk = ~clk; // 100 ns period

	task automatic compare(input string name, input logic [31:0] expected,
	                       input logic [31:0] actual);
		if (actual !== expected) begin
			$display("ERR %0t %s expected %0h actual %0h", $time, name, expected, actual);
			$display("Errors found");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	// no issue and an idle bus
	task automatic idle_inputs();
		sel       = tag_ready;
		operation = '0;
		vj        = '0;
		vk        = '0;
		qj        = tag_ready;
		qk        = tag_ready;
		for (int i = 0; i < num_add; i++) begin
			add_valid[i]  = 1'b0;
			add_result[i] = '0;
		end
		for (int i = 0; i < num_mul; i++) begin
			mul_valid[i]  = 1'b0;
			mul_result[i] = '0;
		end
		ls_valid = 1'b0;
		ls_value = '0;
		ls_idx   = '0;
	endtask

	task automatic issue_op(input tag_t s, input op_t o, input data_t a, input data_t b,
	                        input tag_t ta, input tag_t tb);
		sel       = s;
		operation = o;
		vj        = a;
		vk        = b;
		qj        = ta;
		qk        = tb;
	endtask

	task automatic next_cycle();
		@(negedge clk);
	endtask

	task automatic check_all_idle();
		for (int i = 0; i < num_add; i++) begin
			compare($sformatf("add_busy[%0d]", i), 0, add_busy[i]);
			compare($sformatf("add_start[%0d]", i), 0, add_start[i]);
		end
		for (int i = 0; i < num_mul; i++) begin
			compare($sformatf("mul_busy[%0d]", i), 0, mul_busy[i]);
			compare($sformatf("mul_start[%0d]", i), 0, mul_start[i]);
		end
	endtask

	task automatic test_ready_issue();
		data_t a;
		data_t b;
		a = $urandom();
		b = $urandom();
		issue_op(tag_add_base + 4'd1, 3'd5, a, b, tag_ready, tag_ready); // add station 2
		next_cycle();
		idle_inputs();
		compare("add_start[1]", 1, add_start[1]);
		compare("add_vj[1]", a, add_vj[1]);
		compare("add_vk[1]", b, add_vk[1]);
		compare("add_op[1]", 5, add_op[1]);
		for (int i = 0; i < 3; i++) begin
			next_cycle();
			compare("add_start[1]", 0, add_start[1]);
			compare("add_busy[1]", 1, add_busy[1]);
		end
		add_valid[1]  = 1'b1; // tag 8 on the bus
		add_result[1] = $urandom();
		next_cycle();
		idle_inputs();
		compare("add_busy[1]", 0, add_busy[1]);
	endtask

	task automatic test_wait_add();
		data_t b;
		data_t r;
		b = $urandom();
		r = $urandom();
		issue_op(tag_mul_base, 3'd2, 32'h0, b, tag_add_base, tag_ready);
		next_cycle();
		idle_inputs();
		for (int i = 0; i < 3; i++) begin
			compare("mul_start[0]", 0, mul_start[0]);
			compare("mul_busy[0]", 1, mul_busy[0]);
			next_cycle();
		end
		add_valid[0]  = 1'b1;
		add_result[0] = r;
		next_cycle();
		idle_inputs();
		compare("mul_start[0]", 1, mul_start[0]);
		compare("mul_vj[0]", r, mul_vj[0]);
		compare("mul_vk[0]", b, mul_vk[0]);
		compare("mul_op[0]", 2, mul_op[0]);
		next_cycle();
		compare("mul_start[0]", 0, mul_start[0]);
		mul_valid[0] = 1'b1; // release
		next_cycle();
		idle_inputs();
		compare("mul_busy[0]", 0, mul_busy[0]);
	endtask

	task automatic test_issue_capture();
		data_t r;
		r = $urandom();
		issue_op(tag_mul_base, 3'd3, $urandom(), $urandom(), tag_ready, tag_mul_base + 4'd1);
		mul_valid[1]  = 1'b1; // tag 11 broadcasts during issue
		mul_result[1] = r;
		next_cycle();
		idle_inputs();
		compare("mul_start[0]", 1, mul_start[0]);
		compare("mul_vk[0]", r, mul_vk[0]);
		mul_valid[0] = 1'b1;
		next_cycle();
		idle_inputs();
		compare("mul_busy[0]", 0, mul_busy[0]);
		r = $urandom();
		issue_op(tag_add_base, 3'd1, $urandom(), $urandom(), 4'd4, tag_ready); // load slot 3
		ls_valid = 1'b1;
		ls_idx   = 3'd3;
		ls_value = r;
		next_cycle();
		idle_inputs();
		compare("add_start[0]", 1, add_start[0]);
		compare("add_vj[0]", r, add_vj[0]);
		add_valid[0] = 1'b1;
		next_cycle();
		idle_inputs();
		compare("add_busy[0]", 0, add_busy[0]);
	endtask

	task automatic test_busy_issue();
		data_t a;
		data_t b;
		data_t r;
		a = $urandom();
		b = $urandom();
		r = $urandom();
		issue_op(tag_add_base + 4'd2, 3'd6, a, b, tag_mul_base + 4'd1, tag_ready);
		next_cycle();
		compare("add_busy[2]", 1, add_busy[2]);
		issue_op(tag_add_base + 4'd2, 3'd4, ~a, ~b, tag_ready, tag_ready); // must be ignored
		next_cycle();
		idle_inputs();
		compare("add_start[2]", 0, add_start[2]);
		compare("add_op[2]", 6, add_op[2]);
		compare("add_vj[2]", a, add_vj[2]);
		compare("add_vk[2]", b, add_vk[2]);
		next_cycle();
		compare("add_start[2]", 0, add_start[2]);
		mul_valid[1]  = 1'b1;
		mul_result[1] = r;
		next_cycle();
		idle_inputs();
		compare("add_start[2]", 1, add_start[2]);
		compare("add_vj[2]", r, add_vj[2]);
		compare("add_op[2]", 6, add_op[2]);
		next_cycle();
		compare("add_start[2]", 0, add_start[2]);
		add_valid[2] = 1'b1;
		next_cycle();
		idle_inputs();
		compare("add_busy[2]", 0, add_busy[2]);
	endtask

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("timeout: the tests did not finish within %0d cycles", watchdog_cycles);
		$display("Errors found");
		$fatal(1, "watchdog expired");
	end

	initial begin
		void'($urandom(59407));
		clk   = 1'b0;
		reset = 1'b1;
		idle_inputs();
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		check_all_idle();
		next_cycle();
		test_ready_issue();
		test_wait_add();
		test_issue_capture();
		test_busy_issue();
		check_all_idle();
		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

/* rs_top.f */
hw/rs_tag_pkg.sv
hw/rs_data_pkg.sv
hw/operand_capture.sv
hw/rs_station.sv
hw/rs_top.sv
verif/rs_top_tb.sv

/* Bender.yml */
package:
  name: rs_top

sources:
  # packages first, the stations import both
  - hw/rs_tag_pkg.sv
  - hw/rs_data_pkg.sv

  # reservation stations and top level
  - hw/operand_capture.sv
  - hw/rs_station.sv
  - hw/rs_top.sv

  # directed testbench
  - target: test
    files:
      - verif/rs_top_tb.sv
